//--- src.f
src/bitSlicePkg.sv
src/statusShiftCtrl.sv
src/regFile.sv
src/aluCore.sv
src/bitSliceTop.sv
sim/bitSlice_chk.sv
sim/tbBitSlice.sv

//--- run.sh
#!/usr/bin/env bash
# Build the bit-slice testbench with Verilator, run it and look for the pass line
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert -f src.f --top-module tbBitSlice -o simBitSlice \
   && ./obj_dir/simBitSlice | tee /dev/stderr | grep -qF '** PASS **' \
   && echo "Simulation passed" \
   || { echo "Simulation failed"; exit 1; }

//--- sim/tbBitSlice.sv
`timescale 1ns/1ps

module tbBitSlice;

   localparam int width  = 16;
   localparam int maxPos = (1 << (width-1)) - 1;
   localparam int minNeg = -(1 << (width-1));

   logic                    clk;
   logic                    rstN;
   bitSlicePkg::microInstr  instr;
   logic [width-1:0]        dIn;
   logic                    cx;
   bitSlicePkg::statusFlags statusIn;
   logic [width-1:0]        yOut;
   logic                    ct;
   bitSlicePkg::statusFlags statusOut;

   int checkCount;
   int errorCount;

   // Reference state
   logic [width-1:0]        mRegs [16];
   logic [width-1:0]        mQ;
   bitSlicePkg::statusFlags mUsr;
   bitSlicePkg::statusFlags mMsr;

   // Current-cycle predictions that the next edge commits
   logic [width-1:0]        expY;
   logic                    expCt;
   bitSlicePkg::statusFlags expStatus;
   logic                    pending;
   logic                    nxtWrEn;
   logic [3:0]              nxtWrAddr;
   logic [width-1:0]        nxtWrData;
   logic [width-1:0]        nxtQ;
   bitSlicePkg::statusFlags nxtUsr;
   bitSlicePkg::statusFlags nxtMsr;

   bitSliceTop #(.width(width)) u_bitSliceTop (
      .clk       (clk),
      .rstN      (rstN),
      .instr     (instr),
      .dIn       (dIn),
      .cx        (cx),
      .statusIn  (statusIn),
      .yOut      (yOut),
      .ct        (ct),
      .statusOut (statusOut)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   // Hard stop if the run never reaches its end
   initial begin
      #80000;
      $display("Simulation ran past its cycle limit");
      $display("** FAIL **");
      $finish;
   end

   // ------------------------------
   // Reference model
   // ------------------------------

   // Base test of the even condition codes
   function automatic logic testFlags(bitSlicePkg::statusFlags f, logic [2:0] sel);
      case (sel)
         3'd0:    return (f.sign ^ f.ovr) | f.zero;   // Less or equal
         3'd1:    return f.sign ^ f.ovr;              // Less than
         3'd2:    return f.zero;
         3'd3:    return f.ovr;
         3'd4:    return f.carry | f.zero;
         3'd5:    return f.carry;
         3'd6:    return !f.carry || f.zero;
         default: return f.sign;
      endcase
   endfunction

   // Returns {ram fill, q fill, carry take, carry bit} for a shift link code
   function automatic logic [3:0] linkBits(logic [4:0] code, logic rl, logic rh, logic ql,
                                           logic qh, logic mc, logic ms, logic ac, logic lt);
      case (code)
         5'o00: return 4'b0000;
         5'o01: return 4'b1100;
         5'o02: return {1'b0, ms, 1'b1, rl};
         5'o03: return {1'b1, rl, 2'b00};
         5'o04: return {mc, rl, 2'b00};
         5'o05: return {ms, rl, 2'b00};
         5'o06: return {1'b0, rl, 2'b00};
         5'o07: return {1'b0, rl, 1'b1, ql};
         5'o10: return {rl, ql, 1'b1, rl};
         5'o11: return {mc, ql, 1'b1, rl};
         5'o12: return {rl, ql, 2'b00};
         5'o13: return {ac, rl, 2'b00};
         5'o14: return {mc, rl, 1'b1, ql};
         5'o15: return {ql, rl, 1'b1, ql};
         5'o16: return {lt, rl, 2'b00};
         5'o17: return {ql, rl, 2'b00};
         5'o20: return {2'b00, 1'b1, rh};
         5'o21: return {2'b11, 1'b1, rh};
         5'o22: return 4'b0000;
         5'o23: return 4'b1100;
         5'o24: return {qh, 1'b0, 1'b1, rh};
         5'o25: return {qh, 1'b1, 1'b1, rh};
         5'o26: return {qh, 3'b000};
         5'o27: return {qh, 1'b1, 2'b00};
         5'o30: return {rh, qh, 1'b1, rh};
         5'o31: return {mc, qh, 1'b1, rh};
         5'o32: return {rh, qh, 2'b00};
         5'o33: return {mc, 3'b000};
         5'o34: return {qh, mc, 1'b1, rh};
         5'o35: return {qh, rh, 1'b1, rh};
         5'o36: return {qh, mc, 2'b00};
         default: return {qh, rh, 2'b00};
      endcase
   endfunction

   task automatic predictCycle();
      logic [12:0]             si;
      logic [5:0]              op;
      logic [width-1:0]        r;
      logic [width-1:0]        s;
      logic [width-1:0]        addA;
      logic [width-1:0]        addB;
      logic [width-1:0]        f;
      logic                    cin;
      logic                    arith;
      logic                    base;
      logic [3:0]              link;
      int                      usum;
      int                      ssum;
      bitSlicePkg::statusFlags live;
      bitSlicePkg::statusFlags uNew;
      bitSlicePkg::statusFlags mNew;
      bitSlicePkg::shiftLinks  fl;
      si = instr.statusInstr;
      op = si[5:0];
      // Carry-in comes from the registered carries only
      if (!si[12])
         cin = si[11];
      else if (!si[11])
         cin = cx;
      else
         cin = (si[5] ? mMsr.carry : mUsr.carry) ^ (si[3:1] == 3'd4);
      case (instr.src)
         bitSlicePkg::srcAQ: {r, s} = {mRegs[instr.aSel], mQ};
         bitSlicePkg::srcAB: {r, s} = {mRegs[instr.aSel], mRegs[instr.bSel]};
         bitSlicePkg::srcZQ: {r, s} = {{width{1'b0}}, mQ};
         bitSlicePkg::srcZB: {r, s} = {{width{1'b0}}, mRegs[instr.bSel]};
         bitSlicePkg::srcZA: {r, s} = {{width{1'b0}}, mRegs[instr.aSel]};
         bitSlicePkg::srcDA: {r, s} = {dIn, mRegs[instr.aSel]};
         bitSlicePkg::srcDQ: {r, s} = {dIn, mQ};
         default:            {r, s} = {dIn, {width{1'b0}}};
      endcase
      addA = (instr.func == bitSlicePkg::fnSubR) ? ~r : r;   // S - R
      addB = (instr.func == bitSlicePkg::fnSubS) ? ~s : s;   // R - S
      usum = int'(addA) + int'(addB) + int'(cin);
      ssum = int'($signed(addA)) + int'($signed(addB)) + int'(cin);
      arith = instr.func inside {bitSlicePkg::fnAdd, bitSlicePkg::fnSubR, bitSlicePkg::fnSubS};
      case (instr.func)
         bitSlicePkg::fnOr:    f = r | s;
         bitSlicePkg::fnAnd:   f = r & s;
         bitSlicePkg::fnNotRS: f = ~r & s;
         bitSlicePkg::fnXor:   f = r ^ s;
         bitSlicePkg::fnXnor:  f = ~(r ^ s);
         default:              f = usum[width-1:0];
      endcase
      live.zero  = (f == '0);
      live.sign  = f[width-1];
      live.carry = arith && (usum >= (1 << width));
      live.ovr   = arith && ((ssum > maxPos) || (ssum < minNeg));   // Signed range test
      expY = f;
      // Condition test and status mux
      case (si[5:4])
         2'b10: base = testFlags(mMsr, si[3:1]);
         2'b11: base = testFlags(live, (si[3:1] == 3'd4) ? 3'd6 : si[3:1]);
         default: begin
            if (si[3:1] != 3'd7)
               base = testFlags(mUsr, si[3:1]);
            else
               base = si[4] ? mUsr.sign : (live.sign ^ mMsr.sign);
         end
      endcase
      expCt = base ^ si[0];
      expStatus = (si[5:4] == 2'b10) ? mMsr : ((si[5:4] == 2'b11) ? live : mUsr);
      // Shift linkage
      link = linkBits(si[10:6], f[0], f[width-1], mQ[0], mQ[width-1],
                      mMsr.carry, mMsr.sign, live.carry, live.sign ^ live.ovr);
      fl = '0;
      if (instr.shiftEn && si[10])
         {fl.ramLow, fl.qLow} = link[3:2];       // Up shift fills low ends
      else if (instr.shiftEn)
         {fl.ramHigh, fl.qHigh} = link[3:2];
      // Register file and Q
      nxtWrEn   = instr.dest inside {[3'd2:3'd7]};
      nxtWrAddr = instr.bSel;
      nxtWrData = f;
      nxtQ      = mQ;
      if (instr.dest inside {bitSlicePkg::dstRamQD, bitSlicePkg::dstRamD})
         nxtWrData = {fl.ramHigh, f[width-1:1]};
      if (instr.dest inside {bitSlicePkg::dstRamQU, bitSlicePkg::dstRamU})
         nxtWrData = {f[width-2:0], fl.ramLow};
      if (instr.dest == bitSlicePkg::dstQReg)
         nxtQ = f;
      if (instr.dest == bitSlicePkg::dstRamQD)
         nxtQ = {fl.qHigh, mQ[width-1:1]};
      if (instr.dest == bitSlicePkg::dstRamQU)
         nxtQ = {mQ[width-2:0], fl.qLow};
      // Micro status ops
      uNew = live;
      if (op == 6'o00 || op == 6'o02)
         uNew = mMsr;
      else if (op == 6'o01)
         uNew = '1;
      else if (op == 6'o03)
         uNew = '0;
      else if (op == 6'o06 || op == 6'o07)
         uNew.ovr = live.ovr | mUsr.ovr;
      else if (op inside {6'o30, 6'o31, 6'o50, 6'o51, 6'o70, 6'o71})
         uNew.carry = ~live.carry;
      else if (op inside {[6'o10:6'o17]}) begin
         uNew = mUsr;
         case (op[2:1])
            2'd0: uNew.zero  = op[0];
            2'd1: uNew.carry = op[0];
            2'd2: uNew.sign  = op[0];
            default: uNew.ovr = op[0];
         endcase
      end
      nxtUsr = instr.ceMicro ? uNew : mUsr;
      // Machine status ops
      mNew = live;
      case (op)
         6'o00: mNew = statusIn;
         6'o01: mNew = '1;
         6'o02: mNew = mUsr;                     // Swap
         6'o03: mNew = '0;
         6'o04: {mNew.carry, mNew.ovr} = {mMsr.ovr, mMsr.carry};
         6'o05: mNew = ~mMsr;
         6'o10, 6'o11, 6'o30, 6'o31, 6'o50, 6'o51, 6'o70, 6'o71:
            mNew.carry = ~live.carry;
         default: ;
      endcase
      nxtMsr = mMsr;
      if (instr.ceMachine && instr.enZero)
         nxtMsr.zero = mNew.zero;
      if (instr.ceMachine && instr.enSign)
         nxtMsr.sign = mNew.sign;
      if (instr.ceMachine && instr.enOvr)
         nxtMsr.ovr = mNew.ovr;
      if (instr.shiftEn && link[1])
         nxtMsr.carry = link[0];                 // Shifted-out bit wins
      else if (instr.ceMachine && instr.enCarry)
         nxtMsr.carry = mNew.carry;
      pending = 1'b1;
   endtask

   task automatic commitState();
      if (pending) begin
         if (nxtWrEn)
            mRegs[nxtWrAddr] = nxtWrData;
         mQ      = nxtQ;
         mUsr    = nxtUsr;
         mMsr    = nxtMsr;
         pending = 1'b0;
      end
   endtask

   // ------------------------------
   // Stimulus and checks
   // ------------------------------
   task automatic checkValue(input string name, input logic [31:0] got,
                             input logic [31:0] want);
      checkCount++;
      if (got !== want) begin
         errorCount++;
         $display("CHECK FAILED %s got 0x%h expected 0x%h at %0t", name, got, want, $time);
      end
   endtask

   task automatic checkOutputs();
      checkValue("yOut", 32'(yOut), 32'(expY));
      checkValue("ct", 32'(ct), 32'(expCt));
      checkValue("statusOut", 32'(statusOut), 32'(expStatus));
   endtask

   // Edge, model update, then the drive offset
   task automatic nextEdge();
      @(posedge clk);
      commitState();
      #2;
   endtask

   task automatic idleInstr(input logic [3:0] addr, input logic [2:0] src);
      instr       = '0;
      instr.aSel  = addr;
      instr.src   = src;
      instr.func  = bitSlicePkg::fnOr;           // 0 | operand passes through
      instr.dest  = bitSlicePkg::dstNop;
   endtask

   task automatic randomInstr(input logic shiftHeavy);
      logic [31:0] rnd;
      rnd = $urandom();
      instr.aSel      = rnd[3:0];
      instr.bSel      = rnd[7:4];
      instr.src       = rnd[10:8];
      instr.func      = rnd[13:11];
      instr.dest      = rnd[16:14];
      instr.ceMachine = rnd[17];
      instr.ceMicro   = rnd[18];
      instr.enZero    = rnd[19];
      instr.enCarry   = rnd[20];
      instr.enSign    = rnd[21];
      instr.enOvr     = rnd[22];
      instr.shiftEn   = rnd[23];
      rnd = $urandom();
      instr.statusInstr = rnd[12:0];
      cx       = rnd[13];
      statusIn = rnd[17:14];
      rnd = $urandom();
      dIn = rnd[width-1:0];
      if (shiftHeavy) begin
         instr.shiftEn = 1'b1;
         instr.dest[2] = 1'b1;                   // Shifting destinations only
      end
   endtask

   task automatic runRandom(input int cycles, input logic shiftHeavy);
      for (int i = 0; i < cycles; i++) begin
         nextEdge();
         randomInstr(shiftHeavy);
         predictCycle();
         @(negedge clk);
         checkOutputs();
      end
   endtask

   // Pass each register, then Q, through the ALU
   task automatic readBack();
      for (int i = 0; i < 17; i++) begin
         nextEdge();
         idleInstr(4'(i), (i < 16) ? bitSlicePkg::srcZA : bitSlicePkg::srcZQ);
         predictCycle();
         @(negedge clk);
         checkOutputs();
         checkValue((i < 16) ? $sformatf("reg%0d", i) : "q", 32'(yOut),
                    32'((i < 16) ? mRegs[i] : mQ));
      end
   endtask

   initial begin
      int          waited;
      logic        ready;
      dIn        = width'($urandom(32'h59f2_4f1c));   // First draw seeds the generator
      rstN       = 1'b0;
      cx         = 1'b0;
      statusIn   = '0;
      checkCount = 0;
      errorCount = 0;
      pending    = 1'b0;
      idleInstr(4'd0, bitSlicePkg::srcZA);
      for (int i = 0; i < 16; i++) begin
         mRegs[i] = '0;
      end
      mQ   = '0;
      mUsr = '0;
      mMsr = '0;
      for (int i = 0; i < 5; i++) begin
         @(posedge clk);
      end
      #2 rstN = 1'b1;
      // Outputs settle to the cleared state
      waited = 0;
      ready  = 1'b0;
      while (!ready && waited < 10) begin
         @(negedge clk);
         waited++;
         ready = (yOut === '0) && (statusOut === '0) && (ct === 1'b0);
      end
      if (!ready) begin
         errorCount++;
         $display("Timed out waiting for the outputs to show the reset state");
      end else begin
         predictCycle();
         checkOutputs();
         runRandom(400, 1'b0);
         runRandom(200, 1'b1);
         readBack();
      end
      $display("Checks %0d, errors %0d", checkCount, errorCount);
      if (errorCount == 0)
         $display("** PASS **");
      else
         $display("** FAIL **");
      $finish;
   end

endmodule

//--- sim/bitSlice_chk.sv
`timescale 1ns/1ps

module bitSliceChk (
   input logic                    clk,
   input logic                    rstN,
   input bitSlicePkg::microInstr  instr,
   input logic                    cx,
   input logic                    carryIn,
   input bitSlicePkg::statusFlags uSr,
   input bitSlicePkg::statusFlags mSr
);

   // Both status registers clear on a reset edge
   resetClears: assert property (@(posedge clk) !rstN |=> (uSr == '0) && (mSr == '0))
      else $error("Status registers not cleared by reset");

   // Machine carry holds without its enable or a shift override
   carryHolds: assert property (@(posedge clk) disable iff (!rstN)
      (!instr.shiftEn && !(instr.ceMachine && instr.enCarry)) |=> $stable(mSr.carry))
      else $error("Machine carry changed without enable");

   // I12..I11 = 10 selects the external carry
   carryFromCx: assert property (@(posedge clk) disable iff (!rstN)
      (instr.statusInstr[12:11] == 2'b10) |-> (carryIn == cx))
      else $error("Carry-in does not follow cx");

endmodule

bind statusShiftCtrl bitSliceChk uChk (
   .clk     (clk),
   .rstN    (rstN),
   .instr   (instr),
   .cx      (cx),
   .carryIn (carryIn),
   .uSr     (uSr),
   .mSr     (mSr)
);

//--- src/bitSliceTop.sv
`timescale 1ns/1ps

module bitSliceTop #(
   parameter int width = 16
) (
   input  logic                    clk,
   input  logic                    rstN,
   input  bitSlicePkg::microInstr  instr,
   input  logic [width-1:0]        dIn,
   input  logic                    cx,        // External carry
   input  bitSlicePkg::statusFlags statusIn,
   output logic [width-1:0]        yOut,      // ALU result F
   output logic                    ct,
   output bitSlicePkg::statusFlags statusOut
);

   // Datapath wires
   logic [width-1:0]        aData;
   logic [width-1:0]        bData;
   logic                    carryIn;
   bitSlicePkg::statusFlags aluFlags;
   bitSlicePkg::shiftLinks  ends;
   bitSlicePkg::shiftLinks  fills;

   // ------------------------------
   // Status and shift control
   // ------------------------------
   statusShiftCtrl uCtrl (
      .clk       (clk),
      .rstN      (rstN),
      .instr     (instr),
      .aluFlags  (aluFlags),
      .statusIn  (statusIn),
      .cx        (cx),
      .ends      (ends),
      .carryIn   (carryIn),
      .fills     (fills),
      .ct        (ct),
      .statusOut (statusOut)
   );

   // ------------------------------
   // ALU slice
   // ------------------------------
   regFile #(.width(width)) uRegs (
      .clk   (clk),
      .rstN  (rstN),
      .instr (instr),
      .aluF  (yOut),            // F feeds write-back and the output
      .fills (fills),
      .aData (aData),
      .bData (bData)
   );

   aluCore #(.width(width)) uAlu (
      .clk      (clk),
      .rstN     (rstN),
      .instr    (instr),
      .aData    (aData),
      .bData    (bData),
      .dIn      (dIn),
      .carryIn  (carryIn),
      .fills    (fills),
      .aluF     (yOut),
      .aluFlags (aluFlags),
      .ends     (ends)
   );

endmodule

//--- src/aluCore.sv
`timescale 1ns/1ps

module aluCore #(
   parameter int width = 16
) (
   input  logic                    clk,
   input  logic                    rstN,
   input  bitSlicePkg::microInstr  instr,
   input  logic [width-1:0]        aData,
   input  logic [width-1:0]        bData,
   input  logic [width-1:0]        dIn,
   input  logic                    carryIn,
   input  bitSlicePkg::shiftLinks  fills,
   output logic [width-1:0]        aluF,
   output bitSlicePkg::statusFlags aluFlags,
   output bitSlicePkg::shiftLinks  ends
);

   logic [width-1:0] q;           // Q register
   logic [width-1:0] r;
   logic [width-1:0] s;
   logic [width-1:0] opR;         // R after optional invert
   logic [width-1:0] opS;
   logic [width:0]   sum;         // Carry out on top
   logic             arith;

   // ------------------------------
   // Operand select
   // ------------------------------
   always_comb begin
      case (instr.src)
         bitSlicePkg::srcAQ: {r, s} = {aData, q};
         bitSlicePkg::srcAB: {r, s} = {aData, bData};
         bitSlicePkg::srcZQ: {r, s} = {{width{1'b0}}, q};
         bitSlicePkg::srcZB: {r, s} = {{width{1'b0}}, bData};
         bitSlicePkg::srcZA: {r, s} = {{width{1'b0}}, aData};
         bitSlicePkg::srcDA: {r, s} = {dIn, aData};
         bitSlicePkg::srcDQ: {r, s} = {dIn, q};
         default:            {r, s} = {dIn, {width{1'b0}}};   // DZ
      endcase
   end

   // ------------------------------
   // Adder and logic unit
   // ------------------------------
   // Subtraction is one's complement plus carry-in, as on the 2901
   always_comb begin
      opR = r;
      opS = s;
      case (instr.func)
         bitSlicePkg::fnSubR: opR = ~r;          // S - R
         bitSlicePkg::fnSubS: opS = ~s;          // R - S
         default: ;
      endcase
   end

   assign sum = {1'b0, opR} + {1'b0, opS} + (width+1)'(carryIn);

   always_comb begin
      aluF = sum[width-1:0];
      case (instr.func)
         bitSlicePkg::fnOr:    aluF = r | s;
         bitSlicePkg::fnAnd:   aluF = r & s;
         bitSlicePkg::fnNotRS: aluF = ~r & s;
         bitSlicePkg::fnXor:   aluF = r ^ s;
         bitSlicePkg::fnXnor:  aluF = ~(r ^ s);
         default: ;
      endcase
   end

   assign arith = (instr.func == bitSlicePkg::fnAdd)
                | (instr.func == bitSlicePkg::fnSubR)
                | (instr.func == bitSlicePkg::fnSubS);

   // Logic functions report no carry and no overflow
   assign aluFlags.zero  = (aluF == '0);
   assign aluFlags.sign  = aluF[width-1];
   assign aluFlags.carry = arith & sum[width];
   assign aluFlags.ovr   = arith & (opR[width-1] == opS[width-1])
                         & (aluF[width-1] != opR[width-1]);   // Like signs in, other out

   // ------------------------------
   // Q register and shifter
   // ------------------------------
   always_ff @(posedge clk) begin
      if (!rstN) begin
         q <= '0;
      end else begin
         case (instr.dest)
            bitSlicePkg::dstQReg:  q <= aluF;
            bitSlicePkg::dstRamQD: q <= {fills.qHigh, q[width-1:1]};
            bitSlicePkg::dstRamQU: q <= {q[width-2:0], fills.qLow};
            default: ;                           // Q holds
         endcase
      end
   end

   // End bits that leave the slice on a shift
   assign ends.ramLow  = aluF[0];
   assign ends.ramHigh = aluF[width-1];
   assign ends.qLow    = q[0];
   assign ends.qHigh   = q[width-1];

endmodule

//--- src/regFile.sv
`timescale 1ns/1ps

module regFile #(
   parameter int width = 16
) (
   input  logic                   clk,
   input  logic                   rstN,
   input  bitSlicePkg::microInstr instr,
   input  logic [width-1:0]       aluF,
   input  bitSlicePkg::shiftLinks fills,
   output logic [width-1:0]       aData,
   output logic [width-1:0]       bData
);

   logic [width-1:0] regs [16];
   logic [width-1:0] wrData;
   logic             wrEn;

   // Both read ports are asynchronous
   assign aData = regs[instr.aSel];
   assign bData = regs[instr.bSel];

   // ------------------------------
   // Write-back shifter
   // ------------------------------
   always_comb begin
      wrEn   = 1'b1;
      wrData = aluF;                             // RAMA, RAMF write F as is
      case (instr.dest)
         bitSlicePkg::dstQReg,
         bitSlicePkg::dstNop:
            wrEn = 1'b0;                         // No RAM write
         bitSlicePkg::dstRamQD,
         bitSlicePkg::dstRamD:
            wrData = {fills.ramHigh, aluF[width-1:1]};   // Down, fill at MSB
         bitSlicePkg::dstRamQU,
         bitSlicePkg::dstRamU:
            wrData = {aluF[width-2:0], fills.ramLow};    // Up, fill at LSB
         default: ;
      endcase
   end

   // Write goes to the B address
   always_ff @(posedge clk) begin
      if (!rstN) begin
         for (int i = 0; i < 16; i++) begin
            regs[i] <= '0;
         end
      end else if (wrEn) begin
         regs[instr.bSel] <= wrData;
      end
   end

endmodule

//--- src/statusShiftCtrl.sv
`timescale 1ns/1ps

module statusShiftCtrl (
   input  logic                    clk,
   input  logic                    rstN,
   input  bitSlicePkg::microInstr  instr,
   input  bitSlicePkg::statusFlags aluFlags,   // Live flags from ALU
   input  bitSlicePkg::statusFlags statusIn,   // External status word
   input  logic                    cx,
   input  bitSlicePkg::shiftLinks  ends,       // Shifted-out bits
   output logic                    carryIn,
   output bitSlicePkg::shiftLinks  fills,      // Shifted-in bits
   output logic                    ct,
   output bitSlicePkg::statusFlags statusOut
);

   logic [12:0] si;
   logic [5:0]  op;
   bitSlicePkg::statusFlags uSr;
   bitSlicePkg::statusFlags mSr;
   bitSlicePkg::statusFlags uNext;
   bitSlicePkg::statusFlags mNext;
   logic        linkRam;        // Fill for RAM end
   logic        linkQ;          // Fill for Q end
   logic        ovrTake;        // Shift code claims machine carry
   logic        carryShift;
   logic        carryOverride;
   logic        ctBase;
   logic [2:0]  ctSel;

   assign si = instr.statusInstr;
   assign op = si[5:0];

   // ------------------------------
   // Micro status register
   // ------------------------------
   always_comb begin
      uNext = aluFlags;                          // Plain load by default
      case (op)
         6'o00, 6'o02: uNext = mSr;              // Load from MSR, swap
         6'o01:        uNext = '1;
         6'o03:        uNext = '0;
         6'o06, 6'o07: uNext.ovr = aluFlags.ovr | uSr.ovr;   // Overflow retain
         6'o30, 6'o31, 6'o50, 6'o51, 6'o70, 6'o71:
            uNext.carry = ~aluFlags.carry;
         6'o10, 6'o11: begin
            uNext      = uSr;
            uNext.zero = op[0];                  // Bit 0 is the set value
         end
         6'o12, 6'o13: begin
            uNext       = uSr;
            uNext.carry = op[0];
         end
         6'o14, 6'o15: begin
            uNext      = uSr;
            uNext.sign = op[0];
         end
         6'o16, 6'o17: begin
            uNext     = uSr;
            uNext.ovr = op[0];
         end
         default: ;
      endcase
   end

   // ------------------------------
   // Machine status register
   // ------------------------------
   always_comb begin
      mNext = aluFlags;
      case (op)
         6'o00: mNext = statusIn;
         6'o01: mNext = '1;
         6'o02: mNext = uSr;                     // Swap half
         6'o03: mNext = '0;
         6'o05: mNext = ~mSr;
         6'o04: begin
            // Shift through overflow, C and OVR trade places
            mNext.carry = mSr.ovr;
            mNext.ovr   = mSr.carry;
         end
         6'o10, 6'o11, 6'o30, 6'o31, 6'o50, 6'o51, 6'o70, 6'o71:
            mNext.carry = ~aluFlags.carry;
         default: ;
      endcase
   end

   always_ff @(posedge clk) begin
      if (!rstN) begin
         uSr <= '0;
         mSr <= '0;
      end else begin
         if (instr.ceMicro)
            uSr <= uNext;
         if (instr.ceMachine && instr.enZero)
            mSr.zero <= mNext.zero;
         if (instr.ceMachine && instr.enSign)
            mSr.sign <= mNext.sign;
         if (instr.ceMachine && instr.enOvr)
            mSr.ovr <= mNext.ovr;
         if (carryOverride)
            mSr.carry <= carryShift;             // Shift wins over load
         else if (instr.ceMachine && instr.enCarry)
            mSr.carry <= mNext.carry;
      end
   end

   // ------------------------------
   // Condition test and status mux
   // ------------------------------

   // Even codes of the 2904 table, odd code inverts
   function automatic logic condBase(bitSlicePkg::statusFlags f, logic [2:0] sel);
      case (sel)
         3'd0:    condBase = (f.sign ^ f.ovr) | f.zero;
         3'd1:    condBase = f.sign ^ f.ovr;
         3'd2:    condBase = f.zero;
         3'd3:    condBase = f.ovr;
         3'd4:    condBase = f.carry | f.zero;
         3'd5:    condBase = f.carry;
         3'd6:    condBase = ~f.carry | f.zero;
         default: condBase = f.sign;
      endcase
   endfunction

   always_comb begin
      ctSel = si[3:1];
      case (si[5:4])
         2'b10: ctBase = condBase(mSr, ctSel);
         2'b11: begin
            // Live flags, code 8 repeats the inverted-carry test as on the chip
            if (ctSel == 3'd4)
               ctSel = 3'd6;
            ctBase = condBase(aluFlags, ctSel);
         end
         default: begin
            if (ctSel != 3'd7)
               ctBase = condBase(uSr, ctSel);
            else if (si[4])
               ctBase = uSr.sign;
            else
               ctBase = aluFlags.sign ^ mSr.sign;  // Sign compare, live vs MSR
         end
      endcase
      ct = ctBase ^ si[0];
   end

   always_comb begin
      case (si[5:4])
         2'b10:   statusOut = mSr;
         2'b11:   statusOut = aluFlags;
         default: statusOut = uSr;
      endcase
   end

   // ------------------------------
   // Carry-in mux
   // ------------------------------
   // I12=0 gives the constant in I11, I11=0 then takes cx,
   // else a registered carry picked by I5, inverted for I3..I1 = 4
   always_comb begin
      if (!si[12])
         carryIn = si[11];
      else if (!si[11])
         carryIn = cx;
      else
         carryIn = (si[5] ? mSr.carry : uSr.carry) ^ (si[3:1] == 3'd4);
   end

   // ------------------------------
   // Shift linkage
   // ------------------------------
   // Codes 00..17 shift down (fills go to the high ends),
   // codes 20..37 shift up (fills go to the low ends)
   always_comb begin
      {linkRam, linkQ, ovrTake, carryShift} = '0;
      case (si[10:6])
         5'o00: {linkRam, linkQ} = 2'b00;
         5'o01: {linkRam, linkQ} = 2'b11;
         5'o02: {linkRam, linkQ, ovrTake, carryShift} = {1'b0, mSr.sign, 1'b1, ends.ramLow};
         5'o03: {linkRam, linkQ} = {1'b1, ends.ramLow};
         5'o04: {linkRam, linkQ} = {mSr.carry, ends.ramLow};
         5'o05: {linkRam, linkQ} = {mSr.sign, ends.ramLow};
         5'o06: {linkRam, linkQ} = {1'b0, ends.ramLow};
         5'o07: {linkRam, linkQ, ovrTake, carryShift} = {1'b0, ends.ramLow, 1'b1, ends.qLow};
         5'o10: {linkRam, linkQ, ovrTake, carryShift} =
                   {ends.ramLow, ends.qLow, 1'b1, ends.ramLow};
         5'o11: {linkRam, linkQ, ovrTake, carryShift} =
                   {mSr.carry, ends.qLow, 1'b1, ends.ramLow};
         5'o12: {linkRam, linkQ} = {ends.ramLow, ends.qLow};     // Two rotates
         5'o13: {linkRam, linkQ} = {aluFlags.carry, ends.ramLow};
         5'o14: {linkRam, linkQ, ovrTake, carryShift} =
                   {mSr.carry, ends.ramLow, 1'b1, ends.qLow};
         5'o15: {linkRam, linkQ, ovrTake, carryShift} =
                   {ends.qLow, ends.ramLow, 1'b1, ends.qLow};
         5'o16: {linkRam, linkQ} = {aluFlags.sign ^ aluFlags.ovr, ends.ramLow};
         5'o17: {linkRam, linkQ} = {ends.qLow, ends.ramLow};     // Double rotate
         5'o20: {linkRam, linkQ, ovrTake, carryShift} = {2'b00, 1'b1, ends.ramHigh};
         5'o21: {linkRam, linkQ, ovrTake, carryShift} = {2'b11, 1'b1, ends.ramHigh};
         5'o22: {linkRam, linkQ} = 2'b00;
         5'o23: {linkRam, linkQ} = 2'b11;
         5'o24: {linkRam, linkQ, ovrTake, carryShift} = {ends.qHigh, 1'b0, 1'b1, ends.ramHigh};
         5'o25: {linkRam, linkQ, ovrTake, carryShift} = {ends.qHigh, 1'b1, 1'b1, ends.ramHigh};
         5'o26: {linkRam, linkQ} = {ends.qHigh, 1'b0};
         5'o27: {linkRam, linkQ} = {ends.qHigh, 1'b1};
         5'o30: {linkRam, linkQ, ovrTake, carryShift} =
                   {ends.ramHigh, ends.qHigh, 1'b1, ends.ramHigh};
         5'o31: {linkRam, linkQ, ovrTake, carryShift} =
                   {mSr.carry, ends.qHigh, 1'b1, ends.ramHigh};
         5'o32: {linkRam, linkQ} = {ends.ramHigh, ends.qHigh};
         5'o33: {linkRam, linkQ} = {mSr.carry, 1'b0};
         5'o34: {linkRam, linkQ, ovrTake, carryShift} =
                   {ends.qHigh, mSr.carry, 1'b1, ends.ramHigh};
         5'o35: {linkRam, linkQ, ovrTake, carryShift} =
                   {ends.qHigh, ends.ramHigh, 1'b1, ends.ramHigh};
         5'o36: {linkRam, linkQ} = {ends.qHigh, mSr.carry};
         default: {linkRam, linkQ} = {ends.qHigh, ends.ramHigh};   // 37, double rotate
      endcase
   end

   always_comb begin
      fills = '0;                                // Idle linkage shifts in zeros
      if (instr.shiftEn) begin
         if (si[10]) begin
            fills.ramLow = linkRam;
            fills.qLow   = linkQ;
         end else begin
            fills.ramHigh = linkRam;
            fills.qHigh   = linkQ;
         end
      end
   end

   assign carryOverride = instr.shiftEn & ovrTake;

endmodule

//--- src/bitSlicePkg.sv
package bitSlicePkg;

   // ------------------------------
   // Status word
   // ------------------------------

   // Bit order follows the 2904 registers: Z N C OVR, zero on top
   typedef struct packed {
      logic zero;
      logic sign;
      logic carry;
      logic ovr;
   } statusFlags;

   // Serial end bits of the RAM shifter and the Q shifter
   // Low is bit 0 of the word, high is the MSB
   typedef struct packed {
      logic ramLow;
      logic ramHigh;
      logic qLow;
      logic qHigh;
   } shiftLinks;

   // ------------------------------
   // Microinstruction
   // ------------------------------
   typedef struct packed {
      logic [3:0]  aSel;         // Read port A address
      logic [3:0]  bSel;         // Read port B / write address
      logic [2:0]  src;          // Operand pair R,S
      logic [2:0]  func;         // ALU function
      logic [2:0]  dest;         // Write-back and shift control
      logic [12:0] statusInstr;  // 2904 I12..I0
      logic        ceMachine;    // Machine status reg enable
      logic        ceMicro;      // Micro status reg enable
      logic        enZero;
      logic        enCarry;
      logic        enSign;
      logic        enOvr;
      logic        shiftEn;      // Shift linkage active
   } microInstr;

   // Source operand codes, R first then S
   localparam logic [2:0] srcAQ = 3'd0;
   localparam logic [2:0] srcAB = 3'd1;
   localparam logic [2:0] srcZQ = 3'd2;
   localparam logic [2:0] srcZB = 3'd3;
   localparam logic [2:0] srcZA = 3'd4;
   localparam logic [2:0] srcDA = 3'd5;
   localparam logic [2:0] srcDQ = 3'd6;
   localparam logic [2:0] srcDZ = 3'd7;

   // ALU functions
   localparam logic [2:0] fnAdd   = 3'd0;  // R + S + Cn
   localparam logic [2:0] fnSubR  = 3'd1;  // S - R
   localparam logic [2:0] fnSubS  = 3'd2;  // R - S
   localparam logic [2:0] fnOr    = 3'd3;
   localparam logic [2:0] fnAnd   = 3'd4;
   localparam logic [2:0] fnNotRS = 3'd5;  // ~R & S
   localparam logic [2:0] fnXor   = 3'd6;
   localparam logic [2:0] fnXnor  = 3'd7;

   // Destinations
   localparam logic [2:0] dstQReg  = 3'd0;  // F to Q only
   localparam logic [2:0] dstNop   = 3'd1;
   localparam logic [2:0] dstRamA  = 3'd2;
   localparam logic [2:0] dstRamF  = 3'd3;
   localparam logic [2:0] dstRamQD = 3'd4;  // RAM and Q down
   localparam logic [2:0] dstRamD  = 3'd5;
   localparam logic [2:0] dstRamQU = 3'd6;  // RAM and Q up
   localparam logic [2:0] dstRamU  = 3'd7;

endpackage
